// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f build.f --top-module tb_spi_master -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: build.f
spi_pkg.sv
spi_shift_engine.sv
spi_rx_fifo.sv
spi_axil_regs.sv
spi_master_top.sv
spi_checker.sv
tb_spi_master.sv

// File: spi_axil_regs.sv
`timescale 1ns/100ps

module spi_axil_regs
    import spi_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,

    input  axil_addr_t awaddr_i,
    input  logic       awvalid_i,
    output logic       awready_o,
    input  axil_data_t wdata_i,
    input  logic [3:0] wstrb_i,
    input  logic       wvalid_i,
    output logic       wready_o,
    output logic [1:0] bresp_o,
    output logic       bvalid_o,
    input  logic       bready_i,
    input  axil_addr_t araddr_i,
    input  logic       arvalid_i,
    output logic       arready_o,
    output axil_data_t rdata_o,
    output logic [1:0] rresp_o,
    output logic       rvalid_o,
    input  logic       rready_i,

    output logic       enable_o,
    output logic       lsb_first_o,
    output logic       pol_o,
    output logic       pha_o,
    output spi_delay_t setup_delay_o,
    output spi_delay_t hold_delay_o,
    output spi_div_t   div_o,
    output logic       start_o,
    output spi_byte_t  tx_byte_o,
    input  logic       busy_i,

    input  spi_byte_t  rx_data_i,
    input  logic       rx_empty_i,
    input  logic       rx_full_i,
    input  logic       overflow_i,
    output logic       rx_pop_o,
    output logic       clr_ovf_o
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic       wr_accept;
    logic       rd_accept;
    logic       wr_mapped;
    logic       rd_mapped;
    logic       tx_ok;
    logic [3:0] ctrl_q;
    axil_data_t status_word;
    axil_data_t rd_word;

    assign wr_accept = awvalid_i && wvalid_i && !bvalid_o;
    assign rd_accept = arvalid_i && !rvalid_o;
    assign awready_o = wr_accept;
    assign wready_o  = wr_accept;
    assign arready_o = rd_accept;

    assign wr_mapped = awaddr_i inside {REG_CTRL, REG_DELAY, REG_DIV,
                                        REG_TXDATA, REG_RXDATA, REG_STATUS};
    assign rd_mapped = araddr_i inside {REG_CTRL, REG_DELAY, REG_DIV,
                                        REG_TXDATA, REG_RXDATA, REG_STATUS};

    assign enable_o    = ctrl_q[CTRL_ENABLE];
    assign lsb_first_o = ctrl_q[CTRL_LSB_FIRST];
    assign pol_o       = ctrl_q[CTRL_POL];
    assign pha_o       = ctrl_q[CTRL_PHA];

    assign tx_ok    = enable_o && !busy_i;
    assign rx_pop_o = rd_accept && (araddr_i == REG_RXDATA) && !rx_empty_i;

    always_comb begin
        status_word                = '0;
        status_word[STAT_BUSY]     = busy_i || start_o;   // Covers the start cycle.
        status_word[STAT_RX_EMPTY] = rx_empty_i;
        status_word[STAT_RX_FULL]  = rx_full_i;
        status_word[STAT_OVERFLOW] = overflow_i;
    end

    always_comb begin
        case (araddr_i)
            REG_CTRL:   rd_word = {28'd0, ctrl_q};
            REG_DELAY:  rd_word = {16'd0, hold_delay_o, setup_delay_o};
            REG_DIV:    rd_word = div_o;
            REG_RXDATA: rd_word = rx_empty_i ? '0 : {24'd0, rx_data_i};
            REG_STATUS: rd_word = status_word;
            default:    rd_word = '0;
        endcase
    end

    // Configuration registers, byte lanes per wstrb.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ctrl_q        <= '0;
            setup_delay_o <= '0;
            hold_delay_o  <= '0;
            div_o         <= '0;
        end else if (wr_accept) begin
            case (awaddr_i)
                REG_CTRL: begin
                    if (wstrb_i[0]) ctrl_q <= wdata_i[3:0];
                end
                REG_DELAY: begin
                    if (wstrb_i[0]) setup_delay_o <= wdata_i[7:0];
                    if (wstrb_i[1]) hold_delay_o <= wdata_i[15:8];
                end
                REG_DIV: begin
                    for (int i = 0; i < 4; i++) begin
                        if (wstrb_i[i]) div_o[8*i +: 8] <= wdata_i[8*i +: 8];
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_accept && awaddr_i == REG_TXDATA) begin
            tx_byte_o <= wdata_i[7:0];
        end
        if (rd_accept) begin
            rdata_o <= rd_word;
        end
    end

    // Responses and one-cycle pulses.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            bvalid_o  <= 1'b0;
            bresp_o   <= RESP_OKAY;
            rvalid_o  <= 1'b0;
            rresp_o   <= RESP_OKAY;
            start_o   <= 1'b0;
            clr_ovf_o <= 1'b0;
        end else begin
            start_o   <= 1'b0;
            clr_ovf_o <= 1'b0;

            if (wr_accept) begin
                bvalid_o <= 1'b1;
                bresp_o  <= RESP_OKAY;
                if (!wr_mapped) begin
                    bresp_o <= RESP_SLVERR;
                end else if (awaddr_i == REG_TXDATA) begin
                    if (!tx_ok) begin
                        bresp_o <= RESP_SLVERR;   // Dropped.
                    end else begin
                        start_o <= wstrb_i[0];
                    end
                end else if (awaddr_i == REG_STATUS) begin
                    clr_ovf_o <= wstrb_i[0] && wdata_i[STAT_OVERFLOW];
                end
            end else if (bready_i) begin
                bvalid_o <= 1'b0;
            end

            if (rd_accept) begin
                rvalid_o <= 1'b1;
                rresp_o  <= rd_mapped ? RESP_OKAY : RESP_SLVERR;
            end else if (rready_i) begin
                rvalid_o <= 1'b0;
            end
        end
    end

endmodule

// File: spi_checker.sv
`timescale 1ns/100ps

module spi_checker
    import spi_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,

    input  logic       sck_i,
    input  logic       mosi_i,
    input  logic       cs_i,
    input  logic       pol_i,
    input  logic       pha_i,
    input  logic       lsb_first_i,
    input  spi_delay_t setup_delay_i,
    input  spi_div_t   div_i,
    input  logic       idle_chk_i,

    input  logic       bvalid_i,
    input  logic       bready_i,
    input  logic [1:0] bresp_i,
    input  logic       rvalid_i,
    input  logic       rready_i,
    input  axil_data_t rdata_i,
    input  logic [1:0] rresp_i,

    output int         spi_errs_o,
    output int         axi_errs_o
);

    spi_byte_t  mosi_q [$];
    logic [1:0] bresp_q [$];
    axil_data_t rdata_q [$];
    axil_data_t rmask_q [$];
    logic [1:0] rresp_q [$];

    int         cyc;
    int         fall_cyc;
    logic       wait_edge;
    logic       prev_cs;
    logic       prev_sck;
    int         bit_cnt;
    spi_byte_t  mosi_byte;
    logic       b_wait;
    logic [1:0] b_held;
    logic       r_wait;
    logic [1:0] r_held;
    axil_data_t r_held_data;

    task automatic expect_mosi(input spi_byte_t b);
        mosi_q.push_back(b);
    endtask

    task automatic expect_write(input logic [1:0] resp);
        bresp_q.push_back(resp);
    endtask

    task automatic expect_read(input axil_data_t data, input axil_data_t mask,
                               input logic [1:0] resp);
        rdata_q.push_back(data);
        rmask_q.push_back(mask);
        rresp_q.push_back(resp);
    endtask

    function automatic int pending_count();
        return mosi_q.size() + bresp_q.size() + rdata_q.size();
    endfunction

    // SPI side, sampled on the falling clock edge where the pins are stable.
    initial begin
        spi_errs_o = 0;
        cyc        = 0;
        prev_cs    = 1'b1;
        prev_sck   = 1'b0;
        wait_edge  = 1'b0;
        bit_cnt    = 0;
        mosi_byte  = '0;
    end

    always @(negedge clk_i) begin
        cyc = cyc + 1;
        if (!rst_i) begin
            if (prev_cs && !cs_i) begin
                fall_cyc  = cyc;
                wait_edge = 1'b1;
                bit_cnt   = 0;
                mosi_byte = '0;
            end
            if (!cs_i && sck_i != prev_sck) begin
                if (wait_edge && pha_i &&
                    (cyc - fall_cyc) != int'(setup_delay_i) * (int'(div_i) + 1)) begin
                    $display("CHECK FAILED at %0t: first SCK edge %0d cycles after CS, exp %0d",
                             $time, cyc - fall_cyc,
                             int'(setup_delay_i) * (int'(div_i) + 1));
                    spi_errs_o = spi_errs_o + 1;
                end
                wait_edge = 1'b0;
                // Sample edge is rising when pol equals pha.
                if (sck_i == (pol_i == pha_i) && bit_cnt < 8) begin
                    if (lsb_first_i) mosi_byte[bit_cnt] = mosi_i;
                    else mosi_byte[7 - bit_cnt] = mosi_i;
                    bit_cnt = bit_cnt + 1;
                    if (bit_cnt == 8) begin
                        if (mosi_q.size() == 0) begin
                            $display("Unexpected SPI transfer of byte %02h at %0t",
                                     mosi_byte, $time);
                            spi_errs_o = spi_errs_o + 1;
                        end else if (mosi_q[0] != mosi_byte) begin
                            $display("CHECK FAILED at %0t: MOSI byte %02h, exp %02h",
                                     $time, mosi_byte, mosi_q[0]);
                            spi_errs_o = spi_errs_o + 1;
                            void'(mosi_q.pop_front());
                        end else begin
                            void'(mosi_q.pop_front());
                        end
                    end
                end
            end
            if (idle_chk_i && cs_i && prev_cs && sck_i != pol_i) begin
                $display("CHECK FAILED at %0t: idle SCK %0b, exp %0b", $time, sck_i, pol_i);
                spi_errs_o = spi_errs_o + 1;
            end
        end
        prev_cs  = cs_i;
        prev_sck = sck_i;
    end

    // AXI responses, checked at the handshake edge.
    initial begin
        axi_errs_o = 0;
        b_wait     = 1'b0;
        r_wait     = 1'b0;
    end

    always @(posedge clk_i) begin
        if (!rst_i) begin
            if (b_wait && (!bvalid_i || bresp_i != b_held)) begin
                $display("CHECK FAILED at %0t: B response changed before accept", $time);
                axi_errs_o = axi_errs_o + 1;
            end
            if (bvalid_i && bready_i) begin
                if (bresp_q.size() == 0) begin
                    $display("Write response arrived with none expected at %0t", $time);
                    axi_errs_o = axi_errs_o + 1;
                end else begin
                    if (bresp_i != bresp_q[0]) begin
                        $display("CHECK FAILED at %0t: bresp %0d, exp %0d",
                                 $time, bresp_i, bresp_q[0]);
                        axi_errs_o = axi_errs_o + 1;
                    end
                    void'(bresp_q.pop_front());
                end
            end
            if (r_wait && (!rvalid_i || rresp_i != r_held || rdata_i != r_held_data)) begin
                $display("CHECK FAILED at %0t: R response changed before accept", $time);
                axi_errs_o = axi_errs_o + 1;
            end
            if (rvalid_i && rready_i) begin
                if (rdata_q.size() == 0) begin
                    $display("Read response arrived with none expected at %0t", $time);
                    axi_errs_o = axi_errs_o + 1;
                end else begin
                    if (((rdata_i ^ rdata_q[0]) & rmask_q[0]) != '0 || rresp_i != rresp_q[0]) begin
                        $display("CHECK FAILED at %0t: rdata %08h resp %0d, exp %08h resp %0d",
                                 $time, rdata_i, rresp_i, rdata_q[0], rresp_q[0]);
                        axi_errs_o = axi_errs_o + 1;
                    end
                    void'(rdata_q.pop_front());
                    void'(rmask_q.pop_front());
                    void'(rresp_q.pop_front());
                end
            end
            b_wait      = bvalid_i && !bready_i;
            b_held      = bresp_i;
            r_wait      = rvalid_i && !rready_i;
            r_held      = rresp_i;
            r_held_data = rdata_i;
        end
    end

endmodule

// File: spi_master_top.sv
`timescale 1ns/100ps

module spi_master_top
    import spi_pkg::*;
#(
    parameter int RX_DEPTH = 4
) (
    input  logic       clk_i,
    input  logic       rst_i,

    input  axil_addr_t awaddr_i,
    input  logic       awvalid_i,
    output logic       awready_o,
    input  axil_data_t wdata_i,
    input  logic [3:0] wstrb_i,
    input  logic       wvalid_i,
    output logic       wready_o,
    output logic [1:0] bresp_o,
    output logic       bvalid_o,
    input  logic       bready_i,
    input  axil_addr_t araddr_i,
    input  logic       arvalid_i,
    output logic       arready_o,
    output axil_data_t rdata_o,
    output logic [1:0] rresp_o,
    output logic       rvalid_o,
    input  logic       rready_i,

    output logic       sck_o,
    output logic       mosi_o,
    output logic       cs_o,
    input  logic       miso_i
);

    logic       lsb_first;
    logic       pol;
    logic       pha;
    spi_delay_t setup_delay;
    spi_delay_t hold_delay;
    spi_div_t   div;
    logic       start;
    spi_byte_t  tx_byte;
    logic       busy;
    logic       done;
    spi_byte_t  rx_byte;
    spi_byte_t  fifo_data;
    logic       fifo_empty;
    logic       fifo_full;
    logic       overflow;
    logic       fifo_pop;
    logic       clr_ovf;

    // Enable only gates start inside the register block.
    spi_axil_regs spi_axil_regs_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .awaddr_i      (awaddr_i),
        .awvalid_i     (awvalid_i),
        .awready_o     (awready_o),
        .wdata_i       (wdata_i),
        .wstrb_i       (wstrb_i),
        .wvalid_i      (wvalid_i),
        .wready_o      (wready_o),
        .bresp_o       (bresp_o),
        .bvalid_o      (bvalid_o),
        .bready_i      (bready_i),
        .araddr_i      (araddr_i),
        .arvalid_i     (arvalid_i),
        .arready_o     (arready_o),
        .rdata_o       (rdata_o),
        .rresp_o       (rresp_o),
        .rvalid_o      (rvalid_o),
        .rready_i      (rready_i),
        .enable_o      (),
        .lsb_first_o   (lsb_first),
        .pol_o         (pol),
        .pha_o         (pha),
        .setup_delay_o (setup_delay),
        .hold_delay_o  (hold_delay),
        .div_o         (div),
        .start_o       (start),
        .tx_byte_o     (tx_byte),
        .busy_i        (busy),
        .rx_data_i     (fifo_data),
        .rx_empty_i    (fifo_empty),
        .rx_full_i     (fifo_full),
        .overflow_i    (overflow),
        .rx_pop_o      (fifo_pop),
        .clr_ovf_o     (clr_ovf)
    );

    spi_shift_engine spi_shift_engine_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .lsb_first_i   (lsb_first),
        .pol_i         (pol),
        .pha_i         (pha),
        .setup_delay_i (setup_delay),
        .hold_delay_i  (hold_delay),
        .div_i         (div),
        .start_i       (start),
        .tx_byte_i     (tx_byte),
        .busy_o        (busy),
        .done_o        (done),
        .rx_byte_o     (rx_byte),
        .sck_o         (sck_o),
        .mosi_o        (mosi_o),
        .cs_o          (cs_o),
        .miso_i        (miso_i)
    );

    spi_rx_fifo #(
        .RX_DEPTH (RX_DEPTH)
    ) spi_rx_fifo_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .push_i      (done),
        .push_data_i (rx_byte),
        .pop_i       (fifo_pop),
        .clr_ovf_i   (clr_ovf),
        .pop_data_o  (fifo_data),
        .empty_o     (fifo_empty),
        .full_o      (fifo_full),
        .overflow_o  (overflow)
    );

endmodule

// File: spi_pkg.sv
package spi_pkg;

    // Data and configuration widths.
    typedef logic [7:0]  spi_byte_t;
    typedef logic [7:0]  spi_delay_t;   // CS delay in divided clock periods.
    typedef logic [31:0] spi_div_t;
    typedef logic [7:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_CS_SETUP,
        ENG_XFER,
        ENG_CS_HOLD
    } engine_state_t;

    // Register map.
    localparam axil_addr_t REG_CTRL   = 8'h00;
    localparam axil_addr_t REG_DELAY  = 8'h04;
    localparam axil_addr_t REG_DIV    = 8'h08;
    localparam axil_addr_t REG_TXDATA = 8'h0C;  // Write only.
    localparam axil_addr_t REG_RXDATA = 8'h10;  // A read pops the FIFO.
    localparam axil_addr_t REG_STATUS = 8'h14;

    // CTRL bits.
    localparam int CTRL_ENABLE    = 0;
    localparam int CTRL_LSB_FIRST = 1;
    localparam int CTRL_POL       = 2;
    localparam int CTRL_PHA       = 3;

    // STATUS bits.
    localparam int STAT_BUSY     = 0;
    localparam int STAT_RX_EMPTY = 1;
    localparam int STAT_RX_FULL  = 2;
    localparam int STAT_OVERFLOW = 3;  // Write 1 to clear.

endpackage

// File: spi_rx_fifo.sv
`timescale 1ns/100ps

module spi_rx_fifo
    import spi_pkg::*;
#(
    parameter int RX_DEPTH = 4
) (
    input  logic      clk_i,
    input  logic      rst_i,

    input  logic      push_i,
    input  spi_byte_t push_data_i,
    input  logic      pop_i,
    input  logic      clr_ovf_i,

    output spi_byte_t pop_data_o,
    output logic      empty_o,
    output logic      full_o,
    output logic      overflow_o
);

    localparam int PTR_W = (RX_DEPTH > 1) ? $clog2(RX_DEPTH) : 1;
    localparam int CNT_W = $clog2(RX_DEPTH + 1);

    spi_byte_t        mem_q [RX_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(RX_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty_o    = (count_q == '0);
    assign full_o     = (count_q == CNT_W'(RX_DEPTH));
    assign do_pop     = pop_i && !empty_o;
    assign do_push    = push_i && (!full_o || do_pop);  // A pop frees the slot.
    assign pop_data_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
            if (push_i && !do_push) begin
                overflow_o <= 1'b1;         // Sticky, dropped byte.
            end else if (clr_ovf_i) begin
                overflow_o <= 1'b0;
            end
        end
    end

endmodule

// File: spi_shift_engine.sv
`timescale 1ns/100ps

module spi_shift_engine
    import spi_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,

    input  logic       lsb_first_i,
    input  logic       pol_i,
    input  logic       pha_i,
    input  spi_delay_t setup_delay_i,
    input  spi_delay_t hold_delay_i,
    input  spi_div_t   div_i,

    input  logic       start_i,
    input  spi_byte_t  tx_byte_i,
    output logic       busy_o,
    output logic       done_o,
    output spi_byte_t  rx_byte_o,

    output logic       sck_o,
    output logic       mosi_o,
    output logic       cs_o,
    input  logic       miso_i
);

    engine_state_t state_q;
    spi_div_t      div_cnt_q;
    spi_delay_t    delay_cnt_q;
    logic [2:0]    bits_left_q;     // Bits still to go after the current one.
    spi_byte_t     tx_shift_q;
    spi_byte_t     rx_shift_q;
    spi_byte_t     tx_shift_next;
    spi_byte_t     rx_shift_next;
    logic          period_mid;
    logic          period_end;
    logic          delay_last;

    assign period_mid = (div_cnt_q == (div_i >> 1));
    assign period_end = (div_cnt_q == div_i);
    assign delay_last = (delay_cnt_q == '0);

    assign tx_shift_next = lsb_first_i ? {1'b0, tx_shift_q[7:1]} : {tx_shift_q[6:0], 1'b0};
    assign rx_shift_next = lsb_first_i ? {miso_i, rx_shift_q[7:1]} : {rx_shift_q[6:0], miso_i};

    assign mosi_o    = lsb_first_i ? tx_shift_q[0] : tx_shift_q[7];
    assign rx_byte_o = rx_shift_q;
    assign busy_o    = (state_q != ENG_IDLE);

    // Data path, loaded on start and shifted at each bit boundary.
    always_ff @(posedge clk_i) begin
        if (state_q == ENG_IDLE && start_i) begin
            tx_shift_q <= tx_byte_i;
        end else if (state_q == ENG_XFER && period_end) begin
            tx_shift_q <= tx_shift_next;
            rx_shift_q <= rx_shift_next;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q     <= ENG_IDLE;
            div_cnt_q   <= '0;
            delay_cnt_q <= '0;
            bits_left_q <= '0;
            sck_o       <= 1'b0;
            cs_o        <= 1'b1;
            done_o      <= 1'b0;
        end else begin
            div_cnt_q <= div_cnt_q + 1'b1;
            done_o    <= 1'b0;

            case (state_q)
                ENG_IDLE: begin
                    sck_o <= pol_i;                 // Park SCK at the idle level.
                    if (start_i) begin
                        bits_left_q <= 3'd7;
                        cs_o        <= 1'b0;
                        div_cnt_q   <= '0;
                        if (setup_delay_i == '0) begin
                            state_q <= ENG_XFER;
                            sck_o   <= pol_i ^ pha_i;   // Leading edge now for pha=1.
                        end else begin
                            state_q     <= ENG_CS_SETUP;
                            delay_cnt_q <= setup_delay_i - 1'b1;
                        end
                    end
                end

                ENG_CS_SETUP: begin
                    if (period_end) begin
                        div_cnt_q   <= '0;
                        delay_cnt_q <= delay_cnt_q - 1'b1;
                        if (delay_last) begin
                            state_q <= ENG_XFER;
                            sck_o   <= pol_i ^ pha_i;
                        end
                    end
                end

                ENG_XFER: begin
                    if (period_mid) begin
                        sck_o <= ~sck_o;
                    end
                    if (period_end) begin
                        div_cnt_q <= '0;
                        if (bits_left_q == '0) begin
                            done_o <= 1'b1;         // Lines up with the last shift.
                            sck_o  <= pol_i;
                            if (hold_delay_i == '0) begin
                                state_q <= ENG_IDLE;
                                cs_o    <= 1'b1;
                            end else begin
                                state_q     <= ENG_CS_HOLD;
                                delay_cnt_q <= hold_delay_i - 1'b1;
                            end
                        end else begin
                            bits_left_q <= bits_left_q - 1'b1;
                            sck_o       <= ~sck_o;
                        end
                    end
                end

                ENG_CS_HOLD: begin
                    if (period_end) begin
                        div_cnt_q   <= '0;
                        delay_cnt_q <= delay_cnt_q - 1'b1;
                        if (delay_last) begin
                            state_q <= ENG_IDLE;
                            cs_o    <= 1'b1;
                        end
                    end
                end

                default: begin
                    state_q <= ENG_IDLE;
                end
            endcase
        end
    end

endmodule

// File: tb_spi_master.sv
`timescale 1ns/100ps

module tb_spi_master
    import spi_pkg::*;
;

    localparam int RX_DEPTH  = 4;
    localparam int NUM_RAND  = 16;
    localparam int NUM_XFERS = NUM_RAND + RX_DEPTH + 4;
    localparam int MAX_XFER  = 400;     // Cycles, AXI polling included.
    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;

    logic       clk_i = 1'b0;
    logic       rst_i;
    axil_addr_t awaddr;
    logic       awvalid;
    logic       awready;
    axil_data_t wdata;
    logic [3:0] wstrb;
    logic       wvalid;
    logic       wready;
    logic [1:0] bresp;
    logic       bvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       arready;
    axil_data_t rdata;
    logic [1:0] rresp;
    logic       rvalid;
    logic       rready;
    logic       sck;
    logic       mosi;
    logic       cs;
    logic       miso;

    integer     seed = 32'h3130_588b;
    logic       m_pol, m_pha, m_lsb, bp_en, idle_chk;
    spi_delay_t m_setup;
    spi_div_t   m_div;
    spi_byte_t  reply_q [$];
    spi_byte_t  rx_model [$];
    int         tb_errs, slave_errs, spi_errs, axi_errs;

    always #2 clk_i = ~clk_i;

    spi_master_top #(
        .RX_DEPTH (RX_DEPTH)
    ) spi_master_top_i (
        .clk_i (clk_i), .rst_i (rst_i),
        .awaddr_i (awaddr), .awvalid_i (awvalid), .awready_o (awready),
        .wdata_i (wdata), .wstrb_i (wstrb), .wvalid_i (wvalid), .wready_o (wready),
        .bresp_o (bresp), .bvalid_o (bvalid), .bready_i (bready),
        .araddr_i (araddr), .arvalid_i (arvalid), .arready_o (arready),
        .rdata_o (rdata), .rresp_o (rresp), .rvalid_o (rvalid), .rready_i (rready),
        .sck_o (sck), .mosi_o (mosi), .cs_o (cs), .miso_i (miso)
    );

    spi_checker spi_checker_i (
        .clk_i (clk_i), .rst_i (rst_i), .sck_i (sck), .mosi_i (mosi), .cs_i (cs),
        .pol_i (m_pol), .pha_i (m_pha), .lsb_first_i (m_lsb),
        .setup_delay_i (m_setup), .div_i (m_div), .idle_chk_i (idle_chk),
        .bvalid_i (bvalid), .bready_i (bready), .bresp_i (bresp),
        .rvalid_i (rvalid), .rready_i (rready), .rdata_i (rdata), .rresp_i (rresp),
        .spi_errs_o (spi_errs), .axi_errs_o (axi_errs)
    );

    // SPI slave, shifts on the edge opposite to the sampling edge.
    spi_byte_t reply;
    int        k;
    logic      s_prev_cs = 1'b1;
    logic      s_prev_sck = 1'b0;

    always @(negedge clk_i) begin
        if (s_prev_cs && !cs) begin
            k = 0;
            if (reply_q.size() == 0) begin
                $display("SPI transfer started with no reply byte queued at %0t", $time);
                slave_errs = slave_errs + 1;
                reply = '0;
            end else begin
                reply = reply_q.pop_front();
            end
            if (!m_pha) begin
                miso = m_lsb ? reply[0] : reply[7];
                k = 1;
            end
        end
        if (!cs && sck != s_prev_sck && sck != (m_pol == m_pha) && k < 8) begin
            miso = m_lsb ? reply[k] : reply[7 - k];
            k = k + 1;
        end
        s_prev_cs  = cs;
        s_prev_sck = sck;
    end

    function automatic int hold_cycles();
        int r;
        r = $random(seed);
        return bp_en ? int'(r[2:0] % 5) : 0;
    endfunction

    task automatic axi_write(input axil_addr_t addr, input axil_data_t data,
                             input logic [3:0] strb, input logic [1:0] resp);
        spi_checker_i.expect_write(resp);
        @(negedge clk_i);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(posedge clk_i);
        while (!(awready && wready)) @(posedge clk_i);
        @(negedge clk_i);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        repeat (hold_cycles()) @(negedge clk_i);
        bready = 1'b1;
        @(posedge clk_i);
        while (!bvalid) @(posedge clk_i);
        @(negedge clk_i);
        bready = 1'b0;
    endtask

    task automatic axi_read(input axil_addr_t addr, input axil_data_t exp,
                            input axil_data_t mask, input logic [1:0] resp,
                            output axil_data_t data);
        spi_checker_i.expect_read(exp, mask, resp);
        @(negedge clk_i);
        araddr  = addr;
        arvalid = 1'b1;
        @(posedge clk_i);
        while (!arready) @(posedge clk_i);
        @(negedge clk_i);
        arvalid = 1'b0;
        repeat (hold_cycles()) @(negedge clk_i);
        rready = 1'b1;
        @(posedge clk_i);
        while (!rvalid) @(posedge clk_i);
        data = rdata;
        @(negedge clk_i);
        rready = 1'b0;
    endtask

    task automatic wait_idle();
        axil_data_t st;
        st = 32'h1;
        while (st[STAT_BUSY]) axi_read(REG_STATUS, '0, '0, OKAY, st);
    endtask

    task automatic configure(input logic pol, input logic pha, input logic lsb,
                             input logic en, input spi_div_t div,
                             input spi_delay_t setup, input spi_delay_t hold);
        logic chk;
        chk      = idle_chk;
        idle_chk = 1'b0;                    // SCK follows a new pol one cycle late.
        axi_write(REG_CTRL, {28'd0, pha, pol, lsb, en}, 4'h1, OKAY);
        axi_write(REG_DELAY, {16'd0, hold, setup}, 4'h3, OKAY);
        axi_write(REG_DIV, div, 4'hF, OKAY);
        m_pol   = pol;
        m_pha   = pha;
        m_lsb   = lsb;
        m_div   = div;
        m_setup = setup;
        repeat (2) @(negedge clk_i);
        idle_chk = chk;
    endtask

    task automatic start_transfer(input spi_byte_t tx);
        int r;
        r = $random(seed);
        reply_q.push_back(r[7:0]);
        if (rx_model.size() < RX_DEPTH) rx_model.push_back(r[7:0]);
        spi_checker_i.expect_mosi(tx);
        axi_write(REG_TXDATA, {24'd0, tx}, 4'hF, OKAY);
    endtask

    task automatic read_rx();
        axil_data_t d;
        spi_byte_t  exp;
        exp = (rx_model.size() == 0) ? 8'h00 : rx_model.pop_front();
        axi_read(REG_RXDATA, {24'd0, exp}, 32'hFFFF_FFFF, OKAY, d);
    endtask

    // Watchdog sized from the number of transfers.
    initial begin
        repeat (NUM_XFERS * MAX_XFER * 2) @(posedge clk_i);
        $display("Timeout, the run did not finish in time");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        axil_data_t d;
        int         r;
        rst_i = 1'b1;
        {awaddr, awvalid, wdata, wstrb, wvalid, bready} = '0;
        {araddr, arvalid, rready, miso} = '0;
        {m_pol, m_pha, m_lsb, bp_en, idle_chk} = '0;
        m_setup    = '0;
        m_div      = '0;
        tb_errs    = 0;
        slave_errs = 0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        // All modes and bit orders with random timing and data.
        for (int i = 0; i < NUM_RAND; i++) begin
            r     = $random(seed);
            bp_en = r[12];
            // Two SCK edges per bit need a divider of at least 1.
            configure(i[0], i[1], i[2], 1'b1, spi_div_t'(int'(r[2:0]) % 7 + 1),
                      spi_delay_t'(r[4:3]), spi_delay_t'(r[6:5]));
            r = $random(seed);
            start_transfer(r[7:0]);
            wait_idle();
            idle_chk = 1'b1;
            read_rx();
        end

        // Refused TXDATA writes and unmapped addresses.
        configure(1'b0, 1'b1, 1'b0, 1'b1, 3, 1, 1);
        start_transfer(8'hA5);
        axi_write(REG_TXDATA, 32'h5A, 4'hF, SLVERR);
        wait_idle();
        read_rx();
        configure(1'b0, 1'b1, 1'b0, 1'b0, 3, 1, 1);
        axi_write(REG_TXDATA, 32'h3C, 4'hF, SLVERR);
        axi_write(8'h18, 32'h1, 4'hF, SLVERR);
        axi_read(8'h18, '0, '0, SLVERR, d);

        // FIFO overflow and drain.
        configure(1'b1, 1'b0, 1'b1, 1'b1, 1, 2, 0);
        for (int i = 0; i <= RX_DEPTH; i++) begin
            r = $random(seed);
            start_transfer(r[7:0]);
            wait_idle();
        end
        axi_read(REG_STATUS, 32'h0C, 32'hF, OKAY, d);
        for (int i = 0; i <= RX_DEPTH; i++) read_rx();
        axi_read(REG_STATUS, 32'h0A, 32'hF, OKAY, d);
        axi_write(REG_STATUS, 32'h08, 4'h1, OKAY);
        axi_read(REG_STATUS, 32'h02, 32'hF, OKAY, d);

        repeat (4) @(negedge clk_i);
        if (spi_checker_i.pending_count() != 0 || reply_q.size() != 0) begin
            $display("Expected responses or transfers never arrived");
            tb_errs = tb_errs + 1;
        end
        $display("Errors: spi %0d, axi %0d, slave %0d, testbench %0d",
                 spi_errs, axi_errs, slave_errs, tb_errs);
        if (spi_errs + axi_errs + slave_errs + tb_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
